// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= uart_link_tb
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== byte_credit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Byte handoff from the receiver into the receive FIFO
interface byte_credit_if import uart_types_pkg::*; ();

    logic       valid;      // One-cycle pulse, always accepted
    uart_byte_t data;
    logic       frame_err;  // Stop bit was sampled as 0
    logic       credit;     // One-cycle pulse returns one slot

    modport src (
        output valid,
        output data,
        output frame_err,
        input  credit
    );

    modport dst (
        input  valid,
        input  data,
        input  frame_err,
        output credit
    );

endinterface

`default_nettype wire

// ==== rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fifo import uart_cfg_pkg::*, uart_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    byte_credit_if.dst in,
    input  logic       rx_credit,
    output logic       rx_valid,
    output uart_byte_t rx_data,
    output logic       rx_frame_err
);

    uart_byte_t            data_mem [RX_FIFO_DEPTH];
    logic                  err_mem  [RX_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]   fill_cnt;
    logic [CREDIT_W-1:0]   host_cred;   // Host keeps at most 15 credits outstanding
    logic                  rd;

    // Read only with a byte stored and a host credit in hand
    assign rd = (fill_cnt != '0) && (host_cred != '0);

    // ********************************************************************
    // Storage
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (in.valid) begin
            data_mem[wr_ptr] <= in.data;
            err_mem[wr_ptr]  <= in.frame_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rx_data <= data_mem[rd_ptr];
        end
    end

    // ********************************************************************
    // Pointers, counters and credit return
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill_cnt     <= '0;
            host_cred    <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            in.credit    <= 1'b0;
        end else begin
            if (in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr       <= rd_ptr + 1'b1;
                rx_frame_err <= err_mem[rd_ptr];
            end
            fill_cnt  <= fill_cnt + CREDIT_W'(in.valid) - CREDIT_W'(rd);
            host_cred <= host_cred + CREDIT_W'(rx_credit) - CREDIT_W'(rd);
            rx_valid  <= rd;
            in.credit <= rd;        // Slot freed on the same cycle as rx_valid
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
uart_cfg_pkg.sv
uart_types_pkg.sv
byte_credit_if.sv
uart_tx.sv
uart_rx.sv
rx_fifo.sv
uart_link_top.sv
tb_clock.sv
uart_link_assert.sv
uart_link_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ps

// Free-running testbench clock, 40 ns period (25 MHz)
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #20 clk = ~clk;     // Half period
    end

endmodule

// ==== uart_cfg_pkg.sv ====
package uart_cfg_pkg;

    // ********************************************************************
    // Clock and line rate
    // ********************************************************************
    localparam int unsigned CLK_FREQ       = 32'd25_000_000;    // 25 MHz system clock
    localparam int unsigned BAUD           = 32'd1_000_000;     // 1 Mbaud
    localparam int unsigned CYCLES_PER_BIT = CLK_FREQ / BAUD;   // 25 cycles per bit
    localparam int unsigned HALF_BIT       = CYCLES_PER_BIT / 2;

    // Bit-time counter has to hold CYCLES_PER_BIT itself in the receiver
    localparam int unsigned BIT_CNT_W      = 5;

    // ********************************************************************
    // Buffering and credits
    // ********************************************************************
    localparam int unsigned TX_CREDITS     = 2;                 // Transmit holding slots
    localparam int unsigned RX_FIFO_DEPTH  = 8;                 // Receive FIFO entries
    localparam int unsigned CREDIT_W       = 4;

    // Pointer widths, depths are powers of two so the pointers wrap by themselves
    localparam int unsigned TX_PTR_W       = $clog2(TX_CREDITS);
    localparam int unsigned FIFO_PTR_W     = $clog2(RX_FIFO_DEPTH);

endpackage

// ==== uart_link_assert.sv ====
`timescale 1ns/1ps

module uart_link_assert import uart_cfg_pkg::*, uart_types_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                tx_line,
    input tx_state_t           tx_state,
    input logic                src_valid,     // Receiver to FIFO valid
    input logic                src_credit,    // FIFO to receiver credit pulse
    input logic                rx_valid,
    input logic                rx_credit,     // Host to FIFO credit pulse
    input logic                rx_frame_err
);

    int fail_cnt = 0;
    int src_cred_model;                       // Credits the receiver may still spend
    int host_cred_model;                      // Credits the FIFO may still spend

    // Credit counts rebuilt from the pulses on each side
    always @(posedge clk) begin
        if (rst) begin
            src_cred_model  <= RX_FIFO_DEPTH;
            host_cred_model <= 0;
        end else begin
            src_cred_model  <= src_cred_model - int'(src_valid) + int'(src_credit);
            host_cred_model <= host_cred_model + int'(rx_credit) - int'(rx_valid);
        end
    end

    // ********************************************************************
    // Transmit line
    // ********************************************************************
    idle_line_high: assert property (@(posedge clk) disable iff (rst)
        (tx_state == TX_IDLE) |-> tx_line)
    else begin
        $error("tx_line low while the transmitter is idle");
        fail_cnt++;
    end

    // ********************************************************************
    // Credit rules
    // ********************************************************************
    src_needs_credit: assert property (@(posedge clk) disable iff (rst)
        src_valid |-> (src_cred_model != 0))
    else begin
        $error("Receiver delivered a byte without FIFO credit");
        fail_cnt++;
    end

    host_needs_credit: assert property (@(posedge clk) disable iff (rst)
        rx_valid |-> (host_cred_model != 0))
    else begin
        $error("FIFO output a byte without host credit");
        fail_cnt++;
    end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({rx_valid, rx_frame_err}))
    else begin
        $error("rx_valid or rx_frame_err is unknown");
        fail_cnt++;
    end

endmodule

bind uart_link_top uart_link_assert protocol_chk (
    .clk          (clk),
    .rst          (rst),
    .tx_line      (tx_line),
    .tx_state     (u_tx.state),
    .src_valid    (rx_bus.valid),
    .src_credit   (rx_bus.credit),
    .rx_valid     (rx_valid),
    .rx_credit    (rx_credit),
    .rx_frame_err (rx_frame_err)
);

// ==== uart_link_tb.sv ====
`timescale 1ns/1ps

module uart_link_tb import uart_cfg_pkg::*, uart_types_pkg::*; ();

    // Loopback 20, frame error 3, good frame after glitch 1, back-pressure 8, overrun 9
    localparam int N_FRAMES   = 20 + 3 + 1 + 8 + 9;
    localparam int MAX_CYCLES = 300 * N_FRAMES + 500;

    logic       clk;
    logic       rst;
    logic       tx_valid;
    uart_byte_t tx_data;
    logic       tx_credit;
    logic       tx_line;
    logic       rx_line;
    logic       rx_credit;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_frame_err;
    logic       rx_overrun;

    logic       loop_sel;           // 1 routes tx_line back into rx_line
    logic       gen_line;           // Bit generator output
    int         tx_cred = 0;        // Transmit credits held by the host
    int         rx_seen = 0;
    int         ov_cnt = 0;
    int         cycles = 0;
    int         data_errs = 0;
    int         flag_errs = 0;
    int         stray_errs = 0;
    int         other_errs = 0;
    int         mark;
    integer     seed;
    uart_byte_t pick;
    logic [8:0] exp_head;
    logic [8:0] exp_q [$];          // {frame_err, data} in send order

    tb_clock clk_gen (.clk(clk));

    uart_link_top UUT (
        .clk          (clk),
        .rst          (rst),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .tx_credit    (tx_credit),
        .tx_line      (tx_line),
        .rx_line      (rx_line),
        .rx_credit    (rx_credit),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun)
    );

    assign rx_line = loop_sel ? tx_line : gen_line;

    // A stop bit of 0 must come back flagged
    function automatic logic [8:0] expected_byte(input uart_byte_t sent, input logic stop_bit);
        return {~stop_bit, sent};
    endfunction

    // ********************************************************************
    // Host models and line generator
    // ********************************************************************
    always @(posedge clk) begin
        if (rst) begin
            tx_cred <= 0;
        end else begin
            tx_cred <= tx_cred + int'(tx_credit) - int'(tx_valid);
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input uart_byte_t b);
        while (tx_cred == 0) begin
            tick(1);                // Wait for a credit
        end
        tx_valid = 1'b1;
        tx_data  = b;
        tick(1);
        tx_valid = 1'b0;
    endtask

    task automatic pulse_credits(input int n);
        rx_credit = 1'b1;
        tick(n);
        rx_credit = 1'b0;
    endtask

    task automatic drive_line(input logic v, input int n);
        gen_line = v;
        tick(n);
    endtask

    // Start, 8 data bits LSB first, stop, one idle bit
    task automatic send_frame(input uart_byte_t b, input logic stop_bit);
        drive_line(1'b0, CYCLES_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            drive_line(b[i], CYCLES_PER_BIT);
        end
        if (stop_bit) begin
            drive_line(1'b1, CYCLES_PER_BIT);
        end else begin
            // Low only past the mid-bit sample, the tail reads as a rejected start
            drive_line(1'b0, HALF_BIT + 1);
            drive_line(1'b1, CYCLES_PER_BIT - HALF_BIT - 1);
        end
        drive_line(1'b1, CYCLES_PER_BIT);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            tick(1);
        end
        tick(CYCLES_PER_BIT);       // Room for a stray extra byte
    endtask

    task automatic print_summary();
        $display("Errors: data %0d, frame_err %0d, unexpected %0d, other %0d",
                 data_errs, flag_errs, stray_errs, other_errs);
    endtask

    // ********************************************************************
    // Compare process and timeout
    // ********************************************************************
    always @(negedge clk) begin
        if (!rst && rx_overrun) begin
            ov_cnt++;
        end
        if (!rst && rx_valid) begin
            rx_seen++;
            if (exp_q.size() == 0) begin
                stray_errs++;
                $display("At %0t a byte %h arrived that was never sent", $time, rx_data);
            end else begin
                exp_head = exp_q.pop_front();
                assert (rx_data == exp_head[7:0]) else begin
                    data_errs++;
                    $display("error at %0t: rx_data = %h, expected %h",
                             $time, rx_data, exp_head[7:0]);
                end
                assert (rx_frame_err == exp_head[8]) else begin
                    flag_errs++;
                    $display("error at %0t: rx_frame_err = %b, expected %b",
                             $time, rx_frame_err, exp_head[8]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_summary();
            $display("TEST FAILED");
            $finish;
        end
    end

    // ********************************************************************
    // Test sequence
    // ********************************************************************
    initial begin
        seed      = 32'hfdd7;
        rst       = 1'b1;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_credit = 1'b0;
        loop_sel  = 1'b1;
        gen_line  = 1'b1;
        tick(3);
        rst = 1'b0;

        // Initial transmit credits
        tick(4 * TX_CREDITS);
        assert (tx_cred == int'(TX_CREDITS)) else begin
            other_errs++;
            $display("error at %0t: tx_credit pulses = %0d, expected %0d",
                     $time, tx_cred, TX_CREDITS);
        end

        // Loopback, one host credit per byte
        for (int i = 0; i < 20; i++) begin
            pick = uart_byte_t'($random(seed));
            exp_q.push_back(expected_byte(pick, 1'b1));
            send_byte(pick);
            pulse_credits(1);
        end
        wait_drain();

        // Bad stop bits from the generator
        loop_sel = 1'b0;
        for (int i = 0; i < 3; i++) begin
            pick = uart_byte_t'($random(seed));
            exp_q.push_back(expected_byte(pick, 1'b0));
            pulse_credits(1);
            send_frame(pick, 1'b0);
        end
        wait_drain();

        // Glitch shorter than half a bit, then a good frame
        mark = rx_seen;
        pulse_credits(1);
        drive_line(1'b0, 5);
        drive_line(1'b1, 11 * CYCLES_PER_BIT);  // A false frame would be out by now
        assert (rx_seen == mark) else begin
            other_errs++;
            $display("A short glitch on rx_line was received as a byte");
        end
        pick = uart_byte_t'($random(seed));
        exp_q.push_back(expected_byte(pick, 1'b1));
        send_frame(pick, 1'b1);
        wait_drain();

        // Back-pressure, 8 bytes wait in the FIFO
        loop_sel = 1'b1;
        mark     = rx_seen;
        for (int i = 0; i < 8; i++) begin
            pick = uart_byte_t'($random(seed));
            exp_q.push_back(expected_byte(pick, 1'b1));
            send_byte(pick);
        end
        while (tx_cred != int'(TX_CREDITS)) begin
            tick(1);
        end
        tick(11 * CYCLES_PER_BIT);  // Last frame plus margin
        assert (rx_seen == mark) else begin
            other_errs++;
            $display("rx_valid appeared while the host held no receive credit");
        end
        pulse_credits(8);
        wait_drain();

        // Overrun on the ninth frame
        loop_sel = 1'b0;
        for (int i = 0; i < 9; i++) begin
            pick = uart_byte_t'($random(seed));
            if (i < 8) begin
                exp_q.push_back(expected_byte(pick, 1'b1));
            end else begin
                assert (ov_cnt == 0) else begin
                    other_errs++;
                    $display("error at %0t: rx_overrun pulses = %0d, expected 0",
                             $time, ov_cnt);
                end
            end
            send_frame(pick, 1'b1);
        end
        assert (ov_cnt == 1) else begin
            other_errs++;
            $display("error at %0t: rx_overrun pulses = %0d, expected 1", $time, ov_cnt);
        end
        pulse_credits(9);           // Spare credit would let a kept ninth byte out
        wait_drain();

        other_errs += UUT.protocol_chk.fail_cnt;
        print_summary();
        if (data_errs + flag_errs + stray_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== uart_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_link_top import uart_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Transmit host side
    input  logic       tx_valid,
    input  uart_byte_t tx_data,
    output logic       tx_credit,

    // Serial lines
    output logic       tx_line,
    input  logic       rx_line,

    // Receive host side
    input  logic       rx_credit,
    output logic       rx_valid,
    output uart_byte_t rx_data,
    output logic       rx_frame_err,
    output logic       rx_overrun
);

    // Receiver to FIFO handoff
    byte_credit_if rx_bus ();

    // ********************************************************************
    // Transmit path
    // ********************************************************************
    uart_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .tx_line   (tx_line)
    );

    // ********************************************************************
    // Receive path
    // ********************************************************************
    uart_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_line    (rx_line),
        .out        (rx_bus),
        .rx_overrun (rx_overrun)
    );

    rx_fifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .in           (rx_bus),
        .rx_credit    (rx_credit),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err)
    );

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_cfg_pkg::*, uart_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_line,
    byte_credit_if.src out,
    output logic       rx_overrun
);

    rx_state_t            state;
    logic [BIT_CNT_W-1:0] cyc_cnt;
    logic [2:0]           bit_idx;
    uart_byte_t           shreg;
    logic [CREDIT_W-1:0]  cred_cnt;     // Free FIFO slots as seen from here

    logic                 mid_start;
    logic                 data_sample;
    logic                 stop_sample;
    logic                 deliver;

    // Sample points, counted from the first low cycle seen in idle
    assign mid_start   = (state == RX_START) && (cyc_cnt == BIT_CNT_W'(HALF_BIT));
    assign data_sample = (state == RX_DATA) && (cyc_cnt == BIT_CNT_W'(CYCLES_PER_BIT));
    assign stop_sample = (state == RX_STOP) && (cyc_cnt == BIT_CNT_W'(CYCLES_PER_BIT));
    assign deliver     = stop_sample && (cred_cnt != '0);

    // ********************************************************************
    // Frame FSM
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            cyc_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!rx_line) begin
                        state   <= RX_START;
                        cyc_cnt <= BIT_CNT_W'(1);
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        // A line back at 1 here was only a glitch
                        state   <= rx_line ? RX_IDLE : RX_DATA;
                        cyc_cnt <= BIT_CNT_W'(1);
                        bit_idx <= '0;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (data_sample) begin
                        cyc_cnt <= BIT_CNT_W'(1);
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (stop_sample) begin
                        state <= RX_IDLE;   // Re-armed for an immediate start bit
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (data_sample) begin
            shreg <= {rx_line, shreg[7:1]};
        end
    end

    // ********************************************************************
    // Delivery and credits
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (deliver) begin
            out.data      <= shreg;
            out.frame_err <= ~rx_line;      // Stop bit should be 1
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid  <= 1'b0;
            rx_overrun <= 1'b0;
            cred_cnt   <= CREDIT_W'(RX_FIFO_DEPTH);
        end else begin
            out.valid  <= deliver;
            rx_overrun <= stop_sample && (cred_cnt == '0);  // Byte is dropped
            cred_cnt   <= cred_cnt - CREDIT_W'(deliver) + CREDIT_W'(out.credit);
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_cfg_pkg::*, uart_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_valid,
    input  uart_byte_t tx_data,
    output logic       tx_credit,
    output logic       tx_line
);

    uart_byte_t           hold_mem [TX_CREDITS];
    logic [TX_PTR_W-1:0]  wr_ptr;
    logic [TX_PTR_W-1:0]  rd_ptr;
    logic [CREDIT_W-1:0]  hold_cnt;
    logic [CREDIT_W-1:0]  init_left;    // Credits still owed after reset

    tx_state_t            state;
    logic [BIT_CNT_W-1:0] cyc_cnt;
    logic [2:0]           bit_idx;
    uart_byte_t           shreg;
    logic                 bit_done;
    logic                 pop;
    logic                 shift;

    assign bit_done = (cyc_cnt == BIT_CNT_W'(CYCLES_PER_BIT - 1));

    // Hand a byte to the serializer when idle or right at the end of a stop bit,
    // but only once the reset credit grant is over so credit pulses never collide
    assign pop = (hold_cnt != '0) && (init_left == '0) &&
                 ((state == TX_IDLE) || ((state == TX_STOP) && bit_done));

    assign shift = bit_done && (state == TX_DATA) && (bit_idx != 3'd7);

    // ********************************************************************
    // Holding buffer
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (tx_valid) begin
            hold_mem[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            hold_cnt <= '0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            hold_cnt <= hold_cnt + CREDIT_W'(tx_valid) - CREDIT_W'(pop);
        end
    end

    // Initial grant of TX_CREDITS pulses, then one pulse per pop
    always_ff @(posedge clk) begin
        if (rst) begin
            init_left <= CREDIT_W'(TX_CREDITS);
            tx_credit <= 1'b0;
        end else if (init_left != '0) begin
            init_left <= init_left - 1'b1;
            tx_credit <= 1'b1;
        end else begin
            tx_credit <= pop;
        end
    end

    // ********************************************************************
    // Serializer
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg <= hold_mem[rd_ptr];
        end else if (shift) begin
            shreg <= {1'b0, shreg[7:1]};  // Next bit moves to LSB
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            tx_line <= 1'b1;
            cyc_cnt <= '0;
            bit_idx <= '0;
        end else begin
            cyc_cnt <= bit_done ? '0 : cyc_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    cyc_cnt <= '0;
                    if (pop) begin
                        state   <= TX_START;
                        tx_line <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        tx_line <= shreg[0];
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state   <= TX_STOP;
                            tx_line <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shreg[1];  // Shift happens on this same edge
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        if (pop) begin
                            state   <= TX_START;  // Back-to-back frame, no idle gap
                            tx_line <= 1'b0;
                        end else begin
                            state   <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_types_pkg.sv ====
package uart_types_pkg;

    // One data byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,    // Waiting for a falling edge
        RX_START,   // Confirming the start bit at mid-bit
        RX_DATA,    // Sampling the eight data bits
        RX_STOP     // Sampling the stop bit
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage
